//--- flist.f
hw/dmm_pkg.sv
hw/spi_reg_bank.sv
hw/seq_acquisition.sv
hw/adc_mock.sv
hw/dmm_top.sv
testbench/tb_dmm_top.sv

//--- run_sim.sh
#!/bin/sh
# build the dmm front end testbench with verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_dmm_top \
  -Mdir obj_dir || { echo "verilator build failed"; exit 1; }
./obj_dir/Vtb_dmm_top | tee /dev/stderr | grep "TESTBENCH PASSED" > /dev/null && exit 0 || exit 1

//--- testbench/tb_dmm_top.sv
// dmm front end testbench, spi register access, direct and sequence modes against a model
`timescale 1ns/1ps
`default_nettype none

module tb_dmm_top;
  import dmm_pkg::*;

  localparam int          COUNT_W     = 24;
  localparam int          CLK_PERIOD  = 20;
  localparam logic [31:0] SEED        = 32'h20f72b4b;
  localparam int          ROUNDS      = 2;      // round trip passes
  localparam int          UNDEF_N     = 4;      // unmapped address probes
  localparam int          DIR_ITER    = 4;
  localparam int          SEQ_RUNS    = 2;
  localparam int          FRAME_CYC   = 40 * 8 + 24;   // bits plus select setup and hold
  localparam int          N_FRAMES    = 1 + ROUNDS * 20 + UNDEF_N * 2 + 12 + DIR_ITER * 4
                                        + SEQ_RUNS * 9;
  localparam int          SEQ_CYC     = SEQ_RUNS * (8 * 11 + 40) + 16 * 6 + 20;
  localparam int          WATCHDOG_NS = 2 * (N_FRAMES * FRAME_CYC + SEQ_CYC) * CLK_PERIOD;

  logic        clk_i;
  logic        rst_i;
  logic        sck_i;
  logic        sdi_i;
  logic        trig_i;
  spi_cs_e     cs_vec_i;
  logic [3:0]  hw_flags_i;
  logic        sdo_o;
  logic        spi_glb_clk_o;
  logic        spi_glb_mosi_o;
  logic        spi_4094_strobe_o;
  logic        spi_4094_oe_o;
  logic        spi_invert_dac_clk_o;
  logic        spi_invert_dac_data_o;
  logic        spi_invert_dac_ss_o;
  logic        spi_cs_iso_o;
  out_bundle_t pins_o;

  logic [31:0] rng_state;
  logic [31:0] model_q [0:127];   // mirror of the register file
  logic [2:0]  idx_last_m;        // last recorded entry
  int          checks;
  int          errors;

  dmm_top #(.COUNT_W(COUNT_W)) UUT (
    .clk_i                 (clk_i),
    .rst_i                 (rst_i),
    .sck_i                 (sck_i),
    .sdi_i                 (sdi_i),
    .cs_vec_i              (cs_vec_i),
    .sdo_o                 (sdo_o),
    .hw_flags_i            (hw_flags_i),
    .trig_i                (trig_i),
    .spi_glb_clk_o         (spi_glb_clk_o),
    .spi_glb_mosi_o        (spi_glb_mosi_o),
    .spi_4094_strobe_o     (spi_4094_strobe_o),
    .spi_4094_oe_o         (spi_4094_oe_o),
    .spi_invert_dac_clk_o  (spi_invert_dac_clk_o),
    .spi_invert_dac_data_o (spi_invert_dac_data_o),
    .spi_invert_dac_ss_o   (spi_invert_dac_ss_o),
    .spi_cs_iso_o          (spi_cs_iso_o),
    .pins_o                (pins_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // helpers

  function automatic logic [31:0] rand32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic [31:0] expected_status();
    return {13'd0, model_q[5][2:0], 1'b0, idx_last_m, hw_flags_i, 8'hAA};
  endfunction

  // status, stored word, or zero for holes in the map
  function automatic logic [31:0] expected_read(input logic [6:0] addr);
    if (addr == 7'h00) return expected_status();
    if (addr >= 7'h01 && addr <= 7'h0A) return model_q[addr];
    return 32'd0;
  endfunction

  // sequencer state code for a cycle inside one entry
  // load 1, precharge 2, start 3, wait 4, record 5
  function automatic logic [2:0] seq_state_code(input int cyc, input int pre, input int len);
    if (cyc == 1) return 3'd1;
    if (cyc <= pre + 1) return 3'd2;
    if (cyc == pre + 2) return 3'd3;
    if (cyc < len) return 3'd4;
    return 3'd5;
  endfunction

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] t=%0t ns %0s: got 0x%08h expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic test_done(input string name, input int e0);
    $display("test %-12s %0s, %0d errors", name,
             (errors == e0) ? "ok" : "mismatches", errors - e0);
  endtask

  // one mode 0 bit, 4 clocks low then 4 high, sdo taken just before the rise
  task automatic spi_bit(input logic mosi, output logic miso);
    @(posedge clk_i);
    sck_i <= 1'b0;
    sdi_i <= mosi;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    miso = sdo_o;
    @(posedge clk_i);
    sck_i <= 1'b1;
    repeat (3) @(posedge clk_i);
  endtask

  task automatic spi_frame(input logic [7:0] cmd, input logic [31:0] wdata,
                           output logic [31:0] rdata);
    logic [39:0] tx;
    logic        b;
    tx    = {cmd, wdata};
    rdata = 32'd0;
    @(posedge clk_i);
    cs_vec_i <= CS_FPGA;
    repeat (4) @(posedge clk_i);
    for (int i = 39; i >= 0; i--) begin
      spi_bit(tx[i], b);
      if (i < 32) rdata = {rdata[30:0], b};   // data phase only
    end
    @(posedge clk_i);
    sck_i <= 1'b0;                            // clock idles low
    repeat (4) @(posedge clk_i);
    cs_vec_i <= CS_NONE;
    sdi_i    <= 1'b0;
    repeat (6) @(posedge clk_i);              // commit lands 3 clocks in
  endtask

  task automatic write_reg(input logic [6:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    spi_frame({1'b1, addr}, data, unused);
    if (addr >= 7'h01 && addr <= 7'h0A) model_q[addr] = data;
  endtask

  task automatic read_reg(input logic [6:0] addr, output logic [31:0] data);
    spi_frame({1'b0, addr}, 32'd0, data);
  endtask

  ////////////////////////////////////////////////////////////
  // tests

  task automatic test_reset_state();
    logic [31:0] rd;
    int          e0;
    e0 = errors;
    check(32'(pins_o), 32'd0, "pins after reset");
    check(32'(spi_4094_oe_o), 32'd0, "4094 oe after reset");
    check(32'(sdo_o), 32'd1, "sdo idle level");
    read_reg(7'h00, rd);
    check(rd, expected_status(), "status after reset");
    test_done("reset_state", e0);
  endtask

  task automatic test_round_trip();
    logic [31:0] rd;
    logic [31:0] r;
    logic [6:0]  a;
    int          e0;
    e0 = errors;
    for (int k = 0; k < ROUNDS; k++) begin
      for (int i = 1; i <= 10; i++) write_reg(7'(i), rand32());
      for (int i = 1; i <= 10; i++) begin
        read_reg(7'(i), rd);
        check(rd, expected_read(7'(i)), $sformatf("readback addr 0x%02h", i));
      end
    end
    for (int k = 0; k < UNDEF_N; k++) begin
      r = rand32();
      a = 7'(32'd11 + (r % 32'd117));         // 0x0B..0x7F
      write_reg(a, rand32());
      read_reg(a, rd);
      check(rd, 32'd0, $sformatf("unmapped addr 0x%02h", a));
    end
    write_reg(7'h00, rand32());               // read only, dropped
    read_reg(7'h00, rd);
    check(rd, expected_status(), "status after write attempt");
    for (int i = 1; i <= 10; i++) begin
      read_reg(7'(i), rd);
      check(rd, expected_read(7'(i)), $sformatf("no alias addr 0x%02h", i));
    end
    test_done("round_trip", e0);
  endtask

  task automatic test_direct_mode();
    logic [31:0] dir;
    logic [31:0] oe;
    logic [31:0] r;
    int          m;
    int          e0;
    e0 = errors;
    for (int i = 0; i < DIR_ITER; i++) begin
      dir = rand32();
      oe  = rand32();
      r   = rand32();
      write_reg(7'h01, {r[31:3], 3'd0});      // only the low 3 bits pick the mode
      write_reg(7'h02, dir);
      write_reg(7'h03, oe);
      check(32'(pins_o), {6'd0, dir[25:0]}, "direct pins");
      check(32'(spi_4094_oe_o), 32'(oe[0]), "4094 oe");
      m = int'(r[2:0] % 3'd6) + 1;
      if (m == 6) m = 7;                      // skip the sequencer mode
      write_reg(7'h01, 32'(m));
      check(32'(pins_o), 32'd0, $sformatf("pins in unused mode %0d", m));
    end
    test_done("direct_mode", e0);
  endtask

  task automatic test_cs_decode();
    logic [31:0] r;
    logic [6:0]  got;
    logic [6:0]  exp;
    logic        gc;
    logic        gd;
    int          e0;
    e0 = errors;
    for (int c = 0; c < 8; c++) begin
      for (int k = 0; k < 2; k++) begin
        r = rand32();
        @(posedge clk_i);
        cs_vec_i <= spi_cs_e'(3'(c));
        sck_i    <= r[0];
        sdi_i    <= r[1];
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        gc  = (c == 1) ? 1'b1 : r[0];         // parked while the fpga is selected
        gd  = (c == 1) ? 1'b1 : r[1];
        exp = {gc, gd, c == 2, gc, gd, c != 3, c != 4};
        got = {spi_glb_clk_o, spi_glb_mosi_o, spi_4094_strobe_o, spi_invert_dac_clk_o,
               spi_invert_dac_data_o, spi_invert_dac_ss_o, spi_cs_iso_o};
        check(32'(got), 32'(exp), $sformatf("select decode cs=%0d", c));
      end
    end
    @(posedge clk_i);
    cs_vec_i <= CS_NONE;
    sck_i    <= 1'b0;
    sdi_i    <= 1'b0;
    repeat (8) @(posedge clk_i);
    test_done("cs_decode", e0);
  endtask

  task automatic test_sequence(input int run);
    logic [5:0]  ent [4];
    logic [31:0] r;
    logic [31:0] rd;
    logic [7:0]  mon;
    logic        dup;
    int          n;
    int          pre;
    int          len;
    int          n_rec;
    int          rec;
    int          idx;
    int          cyc;
    int          drop_at;
    int          e0;
    e0 = errors;
    for (int i = 0; i < 4; i++) begin
      dup = 1'b1;
      while (dup) begin
        r      = rand32();
        ent[i] = r[5:0];
        dup    = 1'b0;
        for (int j = 0; j < i; j++) if (ent[j] == ent[i]) dup = 1'b1;
      end
      write_reg(7'(6 + i), {r[31:6], ent[i]});
    end
    r     = rand32();
    n     = int'(r[1:0]) + 1;                 // 1..4 entries
    pre   = int'(r[7:4] % 4'd5);
    len   = pre + ((r[11:8] % 4'd5 == 4'd0) ? 1 : int'(r[11:8] % 4'd5)) + 3;
    n_rec = n + 2 + int'(r[13:12] % 2'd3);    // at least one wrap
    write_reg(7'h05, 32'(n));
    write_reg(7'h04, 32'(pre));
    write_reg(7'h0A, 32'(r[11:8] % 4'd5));
    write_reg(7'h01, 32'd6);
    @(posedge clk_i);
    trig_i <= 1'b1;
    rec     = 0;
    idx     = 0;
    cyc     = 0;
    drop_at = 1 + int'(r[31:16] % 16'(len));  // somewhere in the last entry
    while (rec < n_rec) begin
      @(posedge clk_i);
      cyc++;
      if (rec == n_rec - 1 && cyc == drop_at) trig_i <= 1'b0;
      @(negedge clk_i);
      mon = {3'd0, 2'(idx), seq_state_code(cyc, pre, len)};
      check(32'({pins_o.azmux, pins_o.pc_sw}), 32'(ent[idx]),
            $sformatf("entry %0d switches", idx));
      check(32'(pins_o.leds), 32'(4'b0001 << idx), "leds one hot");
      check(32'(pins_o.monitor), 32'(mon), $sformatf("monitor at cycle %0d", cyc));
      check(32'({pins_o.adc_refmux, pins_o.adc_rstmux, pins_o.adc_sigmux,
                 pins_o.cmpr_latch}), 32'd0, "unused adc lines");
      check(32'(pins_o.adc_reset_n), (cyc >= 2 && cyc <= pre + 1) ? 32'd0 : 32'd1, "adc reset");
      check(32'({pins_o.meas_complete, pins_o.spi_interrupt}), (cyc == len) ? 32'd3 : 32'd0,
            $sformatf("record pulse at cycle %0d of %0d", cyc, len));
      if (cyc == len) begin
        idx_last_m = 3'(idx);
        rec++;
        cyc = 0;
        idx = (idx + 1) % n;
      end
    end
    @(posedge clk_i);
    @(negedge clk_i);
    check(32'(pins_o), 32'd0, "idle after trig drop");
    read_reg(7'h00, rd);
    check(rd, expected_status(), "status after sequence");
    test_done($sformatf("sequence_%0d", run), e0);
  endtask

  ////////////////////////////////////////////////////////////
  // main flow and watchdog

  initial begin
    rng_state  = SEED;
    clk_i      = 1'b0;
    rst_i      = 1'b1;
    sck_i      = 1'b0;
    sdi_i      = 1'b0;
    trig_i     = 1'b0;
    cs_vec_i   = CS_NONE;
    hw_flags_i = 4'(rand32());
    idx_last_m = 3'd0;
    checks     = 0;
    errors     = 0;
    for (int i = 0; i < 128; i++) model_q[i] = 32'd0;
    repeat (8) @(posedge clk_i);
    rst_i <= 1'b0;
    repeat (4) @(posedge clk_i);
    test_reset_state();
    test_round_trip();
    test_direct_mode();
    test_cs_decode();
    for (int k = 0; k < SEQ_RUNS; k++) test_sequence(k);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) $display("TESTBENCH PASSED");
    else $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- hw/dmm_top.sv
// dmm front end control top, spi select decode, register bank and mode selected pin drive
`timescale 1ns/1ps
`default_nettype none

module dmm_top #(
  parameter int COUNT_W = 24
) (
  input  logic                 clk_i,
  input  logic                 rst_i,

  // spi from the mcu
  input  logic                 sck_i,
  input  logic                 sdi_i,
  input  dmm_pkg::spi_cs_e     cs_vec_i,
  output logic                 sdo_o,

  input  logic [3:0]           hw_flags_i,
  input  logic                 trig_i,

  // shared spi lines and selects
  output logic                 spi_glb_clk_o,
  output logic                 spi_glb_mosi_o,
  output logic                 spi_4094_strobe_o,
  output logic                 spi_4094_oe_o,
  output logic                 spi_invert_dac_clk_o,
  output logic                 spi_invert_dac_data_o,
  output logic                 spi_invert_dac_ss_o,
  output logic                 spi_cs_iso_o,

  output dmm_pkg::out_bundle_t pins_o
);
  import dmm_pkg::*;

  logic        cs_fpga;
  reg_file_t   regs;
  status_t     status;
  out_bundle_t seq_bundle;
  logic        seq_trig;
  logic        adc_start;
  logic        adc_reset_n;
  logic        adc_rst;
  logic        meas_valid;
  logic [2:0]  sample_idx_last;

  ////////////////////////////////////////////////////////////
  // select decode

  assign cs_fpga = (cs_vec_i == CS_FPGA);

  assign spi_glb_clk_o  = cs_fpga ? 1'b1 : sck_i;   // park hi while we talk
  assign spi_glb_mosi_o = cs_fpga ? 1'b1 : sdi_i;

  assign spi_4094_strobe_o   = (cs_vec_i == CS_4094);          // active hi
  assign spi_invert_dac_ss_o = (cs_vec_i != CS_INVERT_DAC);    // active lo
  assign spi_cs_iso_o        = (cs_vec_i != CS_MDAC);          // mdac, active lo

  assign spi_invert_dac_clk_o  = spi_glb_clk_o;
  assign spi_invert_dac_data_o = spi_glb_mosi_o;

  ////////////////////////////////////////////////////////////
  // register bank

  always_comb begin
    status                 = '0;
    status.magic           = STATUS_MAGIC;
    status.hw_flags        = hw_flags_i;
    status.sample_idx_last = sample_idx_last;
    status.seq_n           = regs.seq_n;
  end

  spi_reg_bank #(
    .COUNT_W (COUNT_W)
  ) u_regs (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .sck_i    (sck_i),
    .cs_n_i   (!cs_fpga),
    .mosi_i   (sdi_i),
    .status_i (status),
    .miso_o   (sdo_o),
    .regs_o   (regs)
  );

  assign spi_4094_oe_o = regs.oe_4094;   // off until written

  ////////////////////////////////////////////////////////////
  // sequencer and mock adc, mode 6

  assign seq_trig = trig_i && (regs.mode == MODE_SEQ_MOCK);
  assign adc_rst  = rst_i || !adc_reset_n;    // sequencer holds the adc in reset

  seq_acquisition #(
    .COUNT_W (COUNT_W)
  ) u_seq (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .trig_i            (seq_trig),
    .meas_valid_i      (meas_valid),
    .seq_n_i           (regs.seq_n),
    .seq_i             (regs.seq),
    .precharge_i       (regs.precharge[COUNT_W-1:0]),
    .adc_start_o       (adc_start),
    .adc_reset_n_o     (adc_reset_n),
    .bundle_o          (seq_bundle),
    .sample_idx_last_o (sample_idx_last)
  );

  adc_mock #(
    .COUNT_W (COUNT_W)
  ) u_adc (
    .clk_i        (clk_i),
    .rst_i        (adc_rst),
    .start_i      (adc_start),
    .aperture_i   (regs.aperture[COUNT_W-1:0]),
    .meas_valid_o (meas_valid)
  );

  ////////////////////////////////////////////////////////////
  // mode mux

  always_comb begin
    case (regs.mode)
      MODE_DIRECT:   pins_o = regs.direct;   // mcu drives every pin
      MODE_SEQ_MOCK: pins_o = seq_bundle;
      default:       pins_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/adc_mock.sv
// mock adc, ends a conversion after the programmed aperture with a one cycle valid
`timescale 1ns/1ps
`default_nettype none

module adc_mock #(
  parameter int COUNT_W = 24
) (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               start_i,
  input  logic [COUNT_W-1:0] aperture_i,
  output logic               meas_valid_o
);

  logic [COUNT_W-1:0] ap_eff;
  logic [COUNT_W-1:0] rem_q;     // edges left until valid
  logic               busy_q;
  logic               valid_q;

  assign ap_eff = (aperture_i == '0) ? COUNT_W'(1) : aperture_i;   // zero runs as one

  // valid lands aperture+1 cycles from the start cycle, start cycle counted
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q  <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      if (start_i) begin
        if (ap_eff == COUNT_W'(1)) begin
          valid_q <= 1'b1;       // shortest conversion
        end else begin
          busy_q <= 1'b1;
          rem_q  <= ap_eff - 1'b1;
        end
      end else if (busy_q) begin
        if (rem_q == COUNT_W'(1)) begin
          valid_q <= 1'b1;
          busy_q  <= 1'b0;
        end else begin
          rem_q <= rem_q - 1'b1;
        end
      end
    end
  end

  assign meas_valid_o = valid_q;

  a_no_restart: assert property (@(posedge clk_i) disable iff (rst_i) start_i |-> !busy_q);

endmodule

`default_nettype wire

//--- hw/seq_acquisition.sv
// sequence acquisition FSM, steps azmux and precharge through the entries and runs the adc
`timescale 1ns/1ps
`default_nettype none

module seq_acquisition #(
  parameter int COUNT_W = 24
) (
  input  logic                                     clk_i,
  input  logic                                     rst_i,
  input  logic                                     trig_i,
  input  logic                                     meas_valid_i,
  input  logic [2:0]                               seq_n_i,
  input  dmm_pkg::seq_entry_t [dmm_pkg::SEQ_MAX-1:0] seq_i,
  input  logic [COUNT_W-1:0]                       precharge_i,
  output logic                                     adc_start_o,
  output logic                                     adc_reset_n_o,
  output dmm_pkg::out_bundle_t                     bundle_o,
  output logic [2:0]                               sample_idx_last_o
);
  import dmm_pkg::*;

  localparam int IDX_W = $clog2(SEQ_MAX);

  // idle must stay 0, shows on the monitor
  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    LOAD      = 3'd1,
    PRECHARGE = 3'd2,
    START     = 3'd3,
    WAIT_ADC  = 3'd4,
    RECORD    = 3'd5
  } state_e;

  state_e             state_q;
  state_e             state_d;
  logic [IDX_W-1:0]   idx_q;
  logic [IDX_W-1:0]   idx_d;
  logic [COUNT_W-1:0] cnt_q;        // precharge countdown
  logic [2:0]         n_eff;
  logic               last_entry;
  logic               adc_start_q;
  logic [2:0]         idx_last_q;
  out_bundle_t        bundle_q;

  // seq_n of 0 runs one entry, clamp the top end too
  always_comb begin
    if (seq_n_i == 3'd0)          n_eff = 3'd1;
    else if (seq_n_i > SEQ_MAX)   n_eff = 3'(SEQ_MAX);
    else                          n_eff = seq_n_i;
  end

  assign last_entry = (3'(idx_q) + 3'd1) >= n_eff;

  ////////////////////////////////////////////////////////////
  // next state

  always_comb begin
    state_d = state_q;
    idx_d   = idx_q;
    case (state_q)
      IDLE: if (trig_i) begin
        state_d = LOAD;
        idx_d   = '0;
      end
      LOAD:      state_d = (precharge_i == '0) ? START : PRECHARGE;
      PRECHARGE: if (cnt_q <= COUNT_W'(1)) state_d = START;
      START:     state_d = WAIT_ADC;
      WAIT_ADC:  if (meas_valid_i) state_d = RECORD;   // adc cannot stall
      RECORD: begin
        state_d = trig_i ? LOAD : IDLE;   // trig only looked at on a boundary
        idx_d   = (last_entry || !trig_i) ? '0 : idx_q + 1'b1;
      end
      default:   state_d = IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // registered outputs, driven from the next state

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= IDLE;
      idx_q       <= '0;
      cnt_q       <= '0;
      adc_start_q <= 1'b0;
      idx_last_q  <= '0;
      bundle_q    <= '0;
    end else begin
      state_q     <= state_d;
      idx_q       <= idx_d;
      adc_start_q <= (state_d == START);          // single cycle

      if (state_q == LOAD)           cnt_q <= precharge_i;
      else if (state_q == PRECHARGE) cnt_q <= cnt_q - 1'b1;

      if (state_q == RECORD) idx_last_q <= 3'(idx_q);

      // switches follow the entry, park in idle
      if (state_d == LOAD) begin
        bundle_q.azmux <= seq_i[idx_d].azmux;
        bundle_q.pc_sw <= seq_i[idx_d].pc_sw;
      end else if (state_d == IDLE) begin
        bundle_q.azmux <= '0;
        bundle_q.pc_sw <= '0;
      end

      bundle_q.adc_reset_n   <= !(state_d inside {IDLE, PRECHARGE});  // held in reset
      bundle_q.meas_complete <= (state_d == RECORD);
      bundle_q.spi_interrupt <= (state_d == RECORD);    // tells the mcu
      bundle_q.leds          <= (state_d == IDLE) ? 4'b0 : 4'b0001 << idx_d;
      bundle_q.monitor       <= 8'({idx_d, state_d});   // idx above state
    end
  end

  assign bundle_o          = bundle_q;
  assign adc_start_o       = adc_start_q;
  assign adc_reset_n_o     = bundle_q.adc_reset_n;
  assign sample_idx_last_o = idx_last_q;

  // index written back in record stays inside the programmed count
  a_idx_range: assert property (@(posedge clk_i) disable iff (rst_i)
    (state_q == LOAD) |-> (3'(idx_q) < n_eff));

endmodule

`default_nettype wire

//--- hw/spi_reg_bank.sv
// spi register bank, mode 0 slave oversampled in the system clock, 8 bit command + 32 bit data
`timescale 1ns/1ps
`default_nettype none

module spi_reg_bank #(
  parameter int COUNT_W = 24
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      sck_i,
  input  logic                      cs_n_i,
  input  logic                      mosi_i,
  input  logic [dmm_pkg::REG_W-1:0] status_i,
  output logic                      miso_o,
  output dmm_pkg::reg_file_t        regs_o
);
  import dmm_pkg::*;

  localparam int FRAME_BITS = CMD_W + REG_W;     // 40 bits per frame
  localparam int REG_FIRST  = int'(REG_MODE);
  localparam int REG_LAST   = int'(REG_ADC_APERTURE);

  // true for addresses backed by storage
  function automatic logic is_rw(input logic [6:0] addr);
    logic ok;
    case (reg_addr_e'(addr))
      REG_MODE, REG_DIRECT, REG_4094_OE, REG_SA_PRECHARGE, REG_SA_SEQ_N,
      REG_SA_SEQ0, REG_SA_SEQ1, REG_SA_SEQ2, REG_SA_SEQ3, REG_ADC_APERTURE: ok = 1'b1;
      default: ok = 1'b0;
    endcase
    return ok;
  endfunction

  logic [2:0]            sck_sync_q;   // [1] synced, [2] previous
  logic [2:0]            cs_sync_q;
  logic [1:0]            mosi_sync_q;
  logic                  sck_rise;
  logic                  sck_fall;
  logic                  cs_act;
  logic                  cs_end;
  logic [5:0]            bit_cnt_q;
  logic [FRAME_BITS-1:0] shift_q;      // {cmd, data}
  logic [REG_W-1:0]      rd_shift_q;
  logic [REG_W-1:0]      rd_value;
  logic                  reading_q;
  logic                  rd_load;
  logic                  wr_commit;
  logic [6:0]            wr_addr;
  logic [6:0]            rd_addr;
  logic [REG_W-1:0]      mem_q [REG_FIRST:REG_LAST];

  ////////////////////////////////////////////////////////////
  // synchronizers and edge detect

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sck_sync_q  <= '0;
      cs_sync_q   <= '1;     // deselected
      mosi_sync_q <= '0;
    end else begin
      sck_sync_q  <= {sck_sync_q[1:0], sck_i};
      cs_sync_q   <= {cs_sync_q[1:0], cs_n_i};
      mosi_sync_q <= {mosi_sync_q[0], mosi_i};
    end
  end

  assign sck_rise = sck_sync_q[1] & ~sck_sync_q[2];   // sample mosi
  assign sck_fall = ~sck_sync_q[1] & sck_sync_q[2];   // launch miso
  assign cs_act   = ~cs_sync_q[1];
  assign cs_end   = cs_sync_q[1] & ~cs_sync_q[2];     // select released

  assign rd_addr   = shift_q[6:0];                    // cmd byte after 8 bits
  assign wr_addr   = shift_q[FRAME_BITS-2 -: 7];
  assign rd_load   = cs_act && sck_fall && (bit_cnt_q == CMD_W) && !shift_q[CMD_W-1];
  assign wr_commit = cs_end && (bit_cnt_q == FRAME_BITS) && shift_q[FRAME_BITS-1];

  ////////////////////////////////////////////////////////////
  // frame control

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      bit_cnt_q <= '0;
      reading_q <= 1'b0;
    end else if (!cs_act) begin
      bit_cnt_q <= '0;       // short frames die here
      reading_q <= 1'b0;
    end else begin
      if (sck_rise && bit_cnt_q != '1) bit_cnt_q <= bit_cnt_q + 6'd1;  // saturate
      if (rd_load) reading_q <= 1'b1;
    end
  end

  // shifters, payload only
  always_ff @(posedge clk_i) begin
    if (cs_act && sck_rise) shift_q <= {shift_q[FRAME_BITS-2:0], mosi_sync_q[1]};
    if (rd_load) begin
      rd_shift_q <= rd_value;
    end else if (cs_act && sck_fall) begin
      rd_shift_q <= {rd_shift_q[REG_W-2:0], 1'b1};
    end
  end

  assign miso_o = reading_q ? rd_shift_q[REG_W-1] : 1'b1;   // idle high

  // read mux, unmapped reads zero
  always_comb begin
    rd_value = '0;
    if (rd_addr == REG_STATUS) rd_value = status_i;
    else if (is_rw(rd_addr))   rd_value = mem_q[rd_addr];
  end

  ////////////////////////////////////////////////////////////
  // register storage

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = REG_FIRST; i <= REG_LAST; i++) mem_q[i] <= '0;
    end else if (wr_commit && is_rw(wr_addr)) begin
      mem_q[wr_addr] <= shift_q[REG_W-1:0];
    end
  end

  always_comb begin
    regs_o.mode      = mode_e'(mem_q[REG_MODE][2:0]);
    regs_o.direct    = out_bundle_t'(mem_q[REG_DIRECT][$bits(out_bundle_t)-1:0]);
    regs_o.oe_4094   = mem_q[REG_4094_OE][0];
    regs_o.precharge = REG_W'(mem_q[REG_SA_PRECHARGE][COUNT_W-1:0]);
    regs_o.aperture  = REG_W'(mem_q[REG_ADC_APERTURE][COUNT_W-1:0]);
    regs_o.seq_n     = mem_q[REG_SA_SEQ_N][2:0];
    for (int i = 0; i < SEQ_MAX; i++) begin
      regs_o.seq[i] = seq_entry_t'(mem_q[int'(REG_SA_SEQ0) + i][5:0]);
    end
  end

  ////////////////////////////////////////////////////////////
  // checks

  // the 40th bit was already counted before the release, no late bump
  a_commit_len: assert property (@(posedge clk_i) disable iff (rst_i)
    wr_commit |-> ($past(bit_cnt_q) == FRAME_BITS) && !$past(sck_rise));

  // two sync stages plus one register, then miso must be parked
  a_miso_idle: assert property (@(posedge clk_i) disable iff (rst_i)
    cs_n_i [*4] |-> miso_o);

endmodule

`default_nettype wire

//--- hw/dmm_pkg.sv
// dmm front end shared definitions: register map, modes, pin bundle and status layout
`default_nettype none

package dmm_pkg;

  ////////////////////////////////////////////////////////////
  // widths and constants

  localparam int          REG_W        = 32;     // spi data word
  localparam int          CMD_W        = 8;      // rw bit + 7 bit address
  localparam int          SEQ_MAX      = 4;      // sequence entries
  localparam logic [7:0]  STATUS_MAGIC = 8'hAA;  // status byte 0, link check

  ////////////////////////////////////////////////////////////
  // register map

  typedef enum logic [6:0] {
    REG_STATUS       = 7'h00,  // read only
    REG_MODE         = 7'h01,
    REG_DIRECT       = 7'h02,
    REG_4094_OE      = 7'h03,
    REG_SA_PRECHARGE = 7'h04,
    REG_SA_SEQ_N     = 7'h05,
    REG_SA_SEQ0      = 7'h06,
    REG_SA_SEQ1      = 7'h07,
    REG_SA_SEQ2      = 7'h08,
    REG_SA_SEQ3      = 7'h09,
    REG_ADC_APERTURE = 7'h0A
  } reg_addr_e;

  // mode field, anything unlisted blanks the pins
  typedef enum logic [2:0] {
    MODE_DIRECT   = 3'd0,
    MODE_SEQ_MOCK = 3'd6
  } mode_e;

  // select vector line encoding
  typedef enum logic [2:0] {
    CS_NONE       = 3'd0,
    CS_FPGA       = 3'd1,
    CS_4094       = 3'd2,
    CS_INVERT_DAC = 3'd3,
    CS_MDAC       = 3'd4
  } spi_cs_e;

  // mode muxed pin groups, msb first
  typedef struct packed {
    logic       adc_reset_n;    // 25
    logic       meas_complete;  // 24
    logic       spi_interrupt;  // 23
    logic       cmpr_latch;     // 22
    logic       adc_sigmux;     // 21
    logic       adc_rstmux;     // 20
    logic [1:0] adc_refmux;     // 19..18
    logic [3:0] azmux;          // 17..14
    logic [1:0] pc_sw;          // 13..12
    logic [7:0] monitor;        // 11..4
    logic [3:0] leds;           // 3..0
  } out_bundle_t;

  // one sequence step
  typedef struct packed {
    logic [3:0] azmux;
    logic [1:0] pc_sw;
  } seq_entry_t;

  // writable registers as the datapath sees them
  // count fields carry the full word, only the low COUNT_W bits are live
  typedef struct packed {
    mode_e                    mode;
    out_bundle_t              direct;
    logic                     oe_4094;
    logic [REG_W-1:0]         precharge;
    logic [REG_W-1:0]         aperture;
    logic [2:0]               seq_n;
    seq_entry_t [SEQ_MAX-1:0] seq;
  } reg_file_t;

  // status word readback
  typedef struct packed {
    logic [12:0] rsvd_hi;          // 31..19
    logic [2:0]  seq_n;            // 18..16
    logic        rsvd_mid;         // 15
    logic [2:0]  sample_idx_last;  // 14..12
    logic [3:0]  hw_flags;         // 11..8
    logic [7:0]  magic;            // 7..0
  } status_t;

endpackage

`default_nettype wire
